//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // shared request bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  typedef logic [addr_w-1:0] addr_t; // word address on the bus
  typedef logic [data_w-1:0] data_t; // one data word

  // internal startup ram sits at the bottom of the map
  localparam int unsigned int_mem_words = 32; // answers 0 .. 31

  // external program sram follows right after it
  localparam addr_t ext_mem_base = addr_t'(int_mem_words);

  // 512k words of sram behind the base
  localparam addr_t ext_mem_end = ext_mem_base + addr_t'(524287);

  // boot contents of the internal ram, hex words
  localparam string int_mem_file = "startup_ram.mem";

  // anything above ext_mem_end is unmapped
  // and simply never gets a done pulse

endpackage

`default_nettype wire

//--- design/sram_pkg.sv
`default_nettype none

package sram_pkg;

  // word address on the sram chip
  localparam int ext_addr_w = 19;

  typedef logic [ext_addr_w-1:0] ext_addr_t;

  // read/write sequencer of the sram controller
  typedef enum logic [2:0] {
    st_wait,      // idle, looking at the bus
    st_rd_addr,   // put address out, open the chip
    st_rd_get,    // data valid on the pins
    st_rd_finish, // master drops read_q here
    st_wr_addr,   // address and data out
    st_wr_we,     // pull we low
    st_wr_finish  // we low for one cycle, release
  } sram_state_t;

  // ce, oe and we are all active low
  localparam logic strobe_on  = 1'b0;
  localparam logic strobe_off = 1'b1;

endpackage

`default_nettype wire

//--- design/startup_ram.sv
`timescale 1ns/1ps
`default_nettype none

module startup_ram (
  input  logic           clk,
  input  logic           rst,
  input  logic           rw_halt,  // level, blocks new accesses
  input  logic           read_q,
  input  logic           write_q,
  input  bus_pkg::addr_t addr,
  input  bus_pkg::data_t wdata,
  output bus_pkg::data_t rdata,    // zero unless read_dn
  output logic           read_dn,
  output logic           write_dn
);

  import bus_pkg::*;

  data_t mem [0:int_mem_words-1]; // boot image

  logic [$clog2(int_mem_words)-1:0] word_idx;
  logic hit;      // address falls in the internal window
  logic busy;     // current request already served
  logic start;
  logic rd_start;
  logic wr_start;

  initial begin
    $readmemh(int_mem_file, mem); // loaded at elaboration / bitstream
  end

  assign hit      = (addr < addr_t'(int_mem_words));
  assign word_idx = addr[$clog2(int_mem_words)-1:0];

  // serve a request only on its first sampled cycle
  assign start    = (read_q | write_q) & ~busy & ~rw_halt & hit;
  assign rd_start = start & read_q;
  assign wr_start = start & ~read_q; // read wins, master never asserts both

  // array write port
  always_ff @(posedge clk) begin
    if (wr_start) begin
      mem[word_idx] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      rdata    <= '0;
    end else begin
      read_dn  <= 1'b0; // done is a single cycle pulse
      write_dn <= 1'b0;
      rdata    <= '0;   // keep the OR bus clean
      if (!read_q && !write_q) begin
        busy <= 1'b0; // request dropped, ready for the next one
      end else if (start) begin
        busy <= 1'b1;
      end
      if (rd_start) begin
        rdata   <= mem[word_idx];
        read_dn <= 1'b1;
      end
      if (wr_start) begin
        write_dn <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               rw_halt,      // abandons any access in flight
  input  logic               read_q,
  input  logic               write_q,
  input  bus_pkg::addr_t     addr,
  input  bus_pkg::data_t     wdata,
  output bus_pkg::data_t     rdata,        // zero unless read_dn
  output logic               read_dn,
  output logic               write_dn,
  output sram_pkg::ext_addr_t prg_addr,
  output bus_pkg::data_t     prg_wdata,
  input  bus_pkg::data_t     prg_rdata,
  output logic               prg_wdata_oe, // we own the data pins
  output logic               prg_ce,
  output logic               prg_oe,
  output logic               prg_we
);

  import bus_pkg::*;
  import sram_pkg::*;

  sram_state_t state;

  addr_t lat_addr; // bus address taken in st_wait
  data_t lat_data; // write data taken in st_wait

  logic in_map;   // address inside the external window
  logic idle_ok;  // free to take a new request
  logic rd_start;
  logic wr_start;

  assign in_map = (addr >= ext_mem_base) && (addr <= ext_mem_end);

  // a done pulse still on the bus means the master has not dropped yet
  assign idle_ok  = (state == st_wait) && !read_dn && !write_dn;
  assign rd_start = idle_ok && read_q && in_map;
  assign wr_start = idle_ok && write_q && !read_q && in_map;

  // payload path, no reset needed
  always_ff @(posedge clk) begin
    if (rd_start || wr_start) begin
      lat_addr <= addr;
      lat_data <= wdata;
    end
    if (state == st_rd_addr || state == st_wr_addr) begin
      prg_addr  <= ext_addr_t'(lat_addr - ext_mem_base); // bus -> chip offset
      prg_wdata <= lat_data;
    end
  end

  // sequencer and strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= st_wait;
      read_dn      <= 1'b0;
      write_dn     <= 1'b0;
      rdata        <= '0;
      prg_ce       <= strobe_off;
      prg_oe       <= strobe_off;
      prg_we       <= strobe_off;
      prg_wdata_oe <= 1'b0;
    end else begin
      read_dn  <= 1'b0; // single cycle pulses
      write_dn <= 1'b0;
      rdata    <= '0;

      if (rw_halt) begin
        // drop everything, chip deselected, no done
        state        <= st_wait;
        prg_ce       <= strobe_off;
        prg_oe       <= strobe_off;
        prg_we       <= strobe_off;
        prg_wdata_oe <= 1'b0;
      end else begin
        case (state)
          st_wait: begin
            if (rd_start) begin
              state <= st_rd_addr;
            end else if (wr_start) begin
              state <= st_wr_addr;
            end
          end

          // read path
          st_rd_addr: begin
            prg_ce <= strobe_on;
            prg_oe <= strobe_on;
            prg_we <= strobe_off; // read, we stays high
            state  <= st_rd_get;
          end
          st_rd_get: begin
            rdata   <= prg_rdata; // chip output settled this cycle
            read_dn <= 1'b1;
            prg_ce  <= strobe_off;
            prg_oe  <= strobe_off;
            state   <= st_rd_finish;
          end
          st_rd_finish: begin
            state <= st_wait; // master releases read_q meanwhile
          end

          // write path
          st_wr_addr: begin
            prg_ce       <= strobe_on;
            prg_oe       <= strobe_on;
            prg_wdata_oe <= 1'b1; // data out a cycle before we
            state        <= st_wr_we;
          end
          st_wr_we: begin
            prg_we <= strobe_on;
            state  <= st_wr_finish;
          end
          st_wr_finish: begin
            // chip has taken the word on this edge
            prg_we       <= strobe_off;
            prg_ce       <= strobe_off;
            prg_oe       <= strobe_off;
            prg_wdata_oe <= 1'b0;
            write_dn     <= 1'b1;
            state        <= st_wait;
          end

          default: begin
            state <= st_wait;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  logic                clk,
  input  logic                rst,
  input  logic                rw_halt,
  input  bus_pkg::addr_t      addr,
  input  bus_pkg::data_t      wdata,
  input  logic                read_q,
  input  logic                write_q,
  output bus_pkg::data_t      rdata,
  output logic                read_dn,
  output logic                write_dn,
  output sram_pkg::ext_addr_t prg_addr,
  output bus_pkg::data_t      prg_wdata,
  input  bus_pkg::data_t      prg_rdata,
  output logic                prg_wdata_oe,
  output logic                prg_ce,
  output logic                prg_oe,
  output logic                prg_we
);

  import bus_pkg::*;

  // per slave return values, zero when the slave is idle
  data_t int_rdata;
  data_t ext_rdata;
  logic  int_read_dn;
  logic  int_write_dn;
  logic  ext_read_dn;
  logic  ext_write_dn;

  // internal boot ram, addresses below ext_mem_base
  startup_ram i_startup_ram (
    .clk      (clk),
    .rst      (rst),
    .rw_halt  (rw_halt),
    .read_q   (read_q),
    .write_q  (write_q),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (int_rdata),
    .read_dn  (int_read_dn),
    .write_dn (int_write_dn)
  );

  // external program sram
  sram_ctrl i_sram_ctrl (
    .clk          (clk),
    .rst          (rst),
    .rw_halt      (rw_halt),
    .read_q       (read_q),
    .write_q      (write_q),
    .addr         (addr),
    .wdata        (wdata),
    .rdata        (ext_rdata),
    .read_dn      (ext_read_dn),
    .write_dn     (ext_write_dn),
    .prg_addr     (prg_addr),
    .prg_wdata    (prg_wdata),
    .prg_rdata    (prg_rdata),
    .prg_wdata_oe (prg_wdata_oe),
    .prg_ce       (prg_ce),
    .prg_oe       (prg_oe),
    .prg_we       (prg_we)
  );

  // wired-or return bus
  // decode lives in the slaves, at most one answers per access
  assign rdata    = int_rdata | ext_rdata;
  assign read_dn  = int_read_dn | ext_read_dn;
  assign write_dn = int_write_dn | ext_write_dn;

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int half_period  = 20; // 40 ns clock
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // sync reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                clk,
  input  logic                rst,
  input  bus_pkg::addr_t      addr,
  input  bus_pkg::data_t      wdata,
  input  logic                read_q,
  input  logic                write_q,
  input  bus_pkg::data_t      rdata,
  input  logic                read_dn,
  input  logic                write_dn,
  input  sram_pkg::ext_addr_t prg_addr,
  input  logic                prg_ce,
  input  int                  test_id,
  input  logic                test_end,     // close the running test
  input  logic                quiet,        // no done and no chip select expected
  input  logic                missing_done, // master gave up waiting
  output int                  tests_run,
  output int                  tests_failed,
  output int                  errors
);

  import bus_pkg::*;
  import sram_pkg::*;

  localparam int model_words = int_mem_words + 1024; // boot ram + modeled sram window
  localparam int idx_w       = $clog2(model_words);

  data_t shadow [0:model_words-1];
  int run_count   = 0;
  int fail_count  = 0;
  int err_count   = 0;
  int test_errors = 0; // since the last test boundary
  int test_reads  = 0;

  assign tests_run    = run_count;
  assign tests_failed = fail_count;
  assign errors       = err_count;

  initial begin
    for (int i = 0; i < model_words; i++) begin
      shadow[i] = '0; // sram model also starts cleared
    end
    $readmemh(int_mem_file, shadow, 0, int_mem_words - 1);
  end

  function automatic string test_label(input int id);
    case (id)
      0:       return "reset_image";
      1:       return "internal_random";
      2:       return "external_random";
      3:       return "halt";
      4:       return "unmapped";
      default: return "unknown";
    endcase
  endfunction

  // mid-cycle sampling, everything settled
  always @(negedge clk) begin
    logic [idx_w-1:0] idx;
    ext_addr_t        exp_prg;
    idx     = addr[idx_w-1:0];
    exp_prg = ext_addr_t'(addr - ext_mem_base);
    if (!rst) begin
      // a done must belong to the request that is held
      if ((read_dn && !read_q) || (write_dn && !write_q)) begin
        $display("%s: done pulse does not match the request at addr %h",
                 test_label(test_id), addr);
        test_errors++;
      end
      if (read_dn) begin
        test_reads++;
        if (quiet) begin
          $display("%s: read done pulse while none was expected", test_label(test_id));
          test_errors++;
        end else if (addr >= addr_t'(model_words)) begin
          $display("%s: read done for unmodeled addr %h", test_label(test_id), addr);
          test_errors++;
        end else if (rdata !== shadow[idx]) begin
          $display("Fail %s: read addr %h expected %h actual %h",
                   test_label(test_id), addr, shadow[idx], rdata);
          test_errors++;
        end
      end else if (rdata != '0) begin
        $display("%s: rdata %h seen outside a read done", test_label(test_id), rdata);
        test_errors++;
      end
      if (write_dn) begin
        if (quiet || addr >= addr_t'(model_words)) begin
          $display("%s: unexpected write done at addr %h", test_label(test_id), addr);
          test_errors++;
        end else begin
          shadow[idx] = wdata; // access completed, model follows
        end
      end
      if (prg_ce == strobe_on) begin
        if (quiet) begin
          $display("%s: sram selected while no access may start", test_label(test_id));
          test_errors++;
        end else if ((read_q || write_q) && prg_addr !== exp_prg) begin
          $display("Fail %s: prg_addr expected %h actual %h",
                   test_label(test_id), exp_prg, prg_addr);
          test_errors++;
        end
      end
      if (missing_done) begin
        $display("%s: no done pulse within the timeout for addr %h", test_label(test_id), addr);
        test_errors++;
      end
      if (test_end) begin
        run_count++;
        if (test_errors == 0) begin
          $display("test %s: ok, %0d reads checked", test_label(test_id), test_reads);
        end else begin
          $display("test %s: failed with %0d errors", test_label(test_id), test_errors);
          fail_count++;
        end
        err_count   = err_count + test_errors;
        test_errors = 0;
        test_reads  = 0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/sram_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  rw_halt,
  input logic                  read_dn,
  input logic                  write_dn,
  input logic                  prg_ce,
  input logic                  prg_we,
  input sram_pkg::sram_state_t state
);

  import sram_pkg::*;

  // we only with the chip selected
  a_we_needs_ce: assert property (@(posedge clk) disable iff (rst)
    (prg_we == strobe_on) |-> (prg_ce == strobe_on))
    else $error("prg_we active while prg_ce inactive");

  a_read_dn_pulse: assert property (@(posedge clk) disable iff (rst)
    read_dn |=> !read_dn)
    else $error("read_dn high for more than one cycle");

  a_write_dn_pulse: assert property (@(posedge clk) disable iff (rst)
    write_dn |=> !write_dn)
    else $error("write_dn high for more than one cycle");

  // halt throws the sequencer back to idle
  a_halt_to_wait: assert property (@(posedge clk) disable iff (rst)
    rw_halt |=> (state == st_wait))
    else $error("sequencer not idle after rw_halt");

endmodule

bind sram_ctrl sram_ctrl_chk i_sram_ctrl_chk (
  .clk      (clk),
  .rst      (rst),
  .rw_halt  (rw_halt),
  .read_dn  (read_dn),
  .write_dn (write_dn),
  .prg_ce   (prg_ce),
  .prg_we   (prg_we),
  .state    (state)
);

`default_nettype wire

//--- verification/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import bus_pkg::*;
  import sram_pkg::*;

  localparam int timeout_cycles = 50;
  localparam int sram_words     = 1024; // modeled external window
  localparam int rand_seed      = 2234;
  localparam int num_tests      = 5;

  logic      clk;
  logic      rst;
  logic      rw_halt;
  addr_t     addr;
  data_t     wdata;
  logic      read_q;
  logic      write_q;
  data_t     rdata;
  logic      read_dn;
  logic      write_dn;
  ext_addr_t prg_addr;
  data_t     prg_wdata;
  data_t     prg_rdata;
  logic      prg_wdata_oe;
  logic      prg_ce;
  logic      prg_oe;
  logic      prg_we;

  int   test_id;
  logic test_end;
  logic quiet;        // halt and unmapped phases
  logic missing_done;
  int   tests_run;
  int   tests_failed;
  int   errors;
  int   setup_errors;

  data_t sram_mem [0:sram_words-1];

  tb_clock i_clock (.clk(clk), .rst(rst));

  mem_subsystem i_dut (
    .clk(clk), .rst(rst), .rw_halt(rw_halt),
    .addr(addr), .wdata(wdata), .read_q(read_q), .write_q(write_q),
    .rdata(rdata), .read_dn(read_dn), .write_dn(write_dn),
    .prg_addr(prg_addr), .prg_wdata(prg_wdata), .prg_rdata(prg_rdata),
    .prg_wdata_oe(prg_wdata_oe), .prg_ce(prg_ce), .prg_oe(prg_oe), .prg_we(prg_we)
  );

  tb_checker i_checker (
    .clk(clk), .rst(rst), .addr(addr), .wdata(wdata),
    .read_q(read_q), .write_q(write_q), .rdata(rdata),
    .read_dn(read_dn), .write_dn(write_dn), .prg_addr(prg_addr), .prg_ce(prg_ce),
    .test_id(test_id), .test_end(test_end), .quiet(quiet), .missing_done(missing_done),
    .tests_run(tests_run), .tests_failed(tests_failed), .errors(errors)
  );

  // sram chip, async read while selected
  assign prg_rdata = (prg_ce == strobe_on && prg_oe == strobe_on && prg_we == strobe_off)
                     ? sram_mem[prg_addr[9:0]] : 32'hbad0_0bad; // junk when deselected

  always @(posedge clk) begin
    if (prg_ce == strobe_on && prg_we == strobe_on && prg_wdata_oe) begin
      sram_mem[prg_addr[9:0]] <= prg_wdata; // we-low cycle
    end
  end

  function automatic addr_t pick_int_addr();
    return addr_t'($urandom_range(int_mem_words - 1, 0));
  endfunction

  // half the picks hit a small hot set so reads meet earlier writes
  function automatic addr_t pick_ext_addr();
    if ($urandom_range(1, 0) == 1) begin
      return ext_mem_base + addr_t'($urandom_range(15, 0));
    end
    return ext_mem_base + addr_t'($urandom_range(sram_words - 1, 0));
  endfunction

  // look for a done mid-cycle, bounded by the timeout
  task automatic wait_done(output logic got_done);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < timeout_cycles) begin
      @(negedge clk);
      seen = read_dn | write_dn;
      n++;
    end
    got_done = seen;
  endtask

  // release the request, flag a done that never came
  task automatic drop_request(input logic missing);
    @(posedge clk);
    read_q       <= 1'b0;
    write_q      <= 1'b0;
    missing_done <= missing;
    @(posedge clk);
    missing_done <= 1'b0;
  endtask

  // one request, held until done or timeout, then dropped
  task automatic bus_access(input logic is_write, input addr_t a, input data_t d,
                            input logic want_done);
    logic got_done;
    @(posedge clk);
    addr    <= a;
    wdata   <= d;
    read_q  <= ~is_write;
    write_q <= is_write;
    wait_done(got_done);
    drop_request(want_done & ~got_done);
  endtask

  // request raised under halt stays pending, finishes once halt drops
  task automatic halted_access(input logic is_write, input addr_t a, input data_t d);
    logic got_done;
    @(posedge clk);
    rw_halt <= 1'b1;
    quiet   <= 1'b1;
    addr    <= a;
    wdata   <= d;
    read_q  <= ~is_write;
    write_q <= is_write;
    wait_done(got_done); // any done here is an error
    @(posedge clk);
    rw_halt <= 1'b0;
    quiet   <= 1'b0; // same request still held
    wait_done(got_done);
    drop_request(~got_done);
  endtask

  task automatic close_test();
    @(posedge clk);
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    test_id  <= test_id + 1;
  endtask

  initial begin
    int    seed_dummy;
    int    n;
    addr_t held_addr;
    logic  held_wr;
    data_t held_data;
    seed_dummy   = $urandom(rand_seed); // seeds the generator once
    rw_halt      <= 1'b0;
    addr         <= '0;
    wdata        <= '0;
    read_q       <= 1'b0;
    write_q      <= 1'b0;
    test_id      <= 0;
    test_end     <= 1'b0;
    quiet        <= 1'b0;
    missing_done <= 1'b0;
    setup_errors = 0;
    for (int i = 0; i < sram_words; i++) begin
      sram_mem[i] = '0;
    end

    n = 0;
    @(posedge clk);
    while (rst && n < timeout_cycles) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      $display("reset was never released");
      setup_errors++;
    end

    // boot image readback
    for (int i = 0; i < int_mem_words; i++) begin
      bus_access(1'b0, addr_t'(i), '0, 1'b1);
    end
    close_test();

    repeat (48) begin
      bus_access($urandom_range(1, 0) == 1, pick_int_addr(), data_t'($urandom()), 1'b1);
    end
    close_test();

    repeat (64) begin
      bus_access($urandom_range(1, 0) == 1, pick_ext_addr(), data_t'($urandom()), 1'b1);
    end
    close_test();

    // requests under halt get nothing, then go through
    for (int k = 0; k < 4; k++) begin
      held_addr = ((k % 2) == 1) ? pick_ext_addr() : pick_int_addr();
      held_wr   = ($urandom_range(1, 0) == 1);
      held_data = data_t'($urandom());
      halted_access(held_wr, held_addr, held_data);
      bus_access(1'b0, held_addr, '0, 1'b1); // readback
    end
    close_test();

    // past the end of the map, then a normal read
    @(posedge clk);
    quiet <= 1'b1;
    bus_access(1'b0, ext_mem_end + 1 + addr_t'($urandom_range(255, 0)), '0, 1'b0);
    bus_access(1'b0, 32'hffff_fff0 | addr_t'($urandom_range(15, 0)), '0, 1'b0);
    @(posedge clk);
    quiet <= 1'b0;
    bus_access(1'b0, pick_ext_addr(), '0, 1'b1);
    bus_access(1'b0, pick_int_addr(), '0, 1'b1);
    close_test();

    @(posedge clk);
    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, errors + setup_errors);
    if (errors == 0 && setup_errors == 0 && tests_run == num_tests) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
design/bus_pkg.sv
design/sram_pkg.sv
design/startup_ram.sv
design/sram_ctrl.sv
design/mem_subsystem.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/sram_ctrl_chk.sv
verification/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# verilator build and run of the memory subsystem testbench
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module tb_top -o Vtb_top \
  || { echo "verilator build failed"; exit 1; }

# startup_ram.mem is opened by bare name, so the binary runs next to it
(cd design && ../obj_dir/Vtb_top) > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log

grep -q "SIMULATION FAILED" sim.log \
  && { echo "testbench reported a failure"; exit 1; }
grep -q "SIMULATION PASSED" sim.log \
  || { echo "no pass message in sim.log"; exit 1; }

echo "run finished clean"

//--- design/startup_ram.mem
// internal startup ram boot image, one 32-bit hex word per line
// line n holds the word at bus address n (0 .. 31)
3c1d0000
27bd0400
3c080000
25080020
8d090000
ad090004
21080004
1500fffc
00000000
0bf00010
3c0a0008
254a0000
01404809
00000000
8c0b0010
116000fe
240c0001
ac0c0014
3c0d1234
35ad5678
ad0d0018
8d0e0018
11cd0002
00000000
0800001a
240f00ff
ac0f001c
03e00008
a5a5a5a5
5a5a5a5a
deadc0de
0000ffff
